/* panel_io.f */
+incdir+source
source/panel_types_pkg.sv
source/host_cmd_pkg.sv
source/button_sampler.sv
source/button_debounce.sv
source/panel_status.sv
source/panel_io.sv
verif/panel_io_assertions.sv
verif/panel_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the panel_io testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module panel_io_tb \
	-f panel_io.f \
	--Mdir obj_dir \
	-o panel_io_sim

./obj_dir/panel_io_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi

echo "Run passed"
exit 0

/* verif/panel_io_tb.sv */
// Testbench for the board panel, runs a stimulus table through panel_io and checks LEDs and status
`timescale 1ns/1ps
`include "panel_consts.svh"

module panel_io_tb
	import panel_types_pkg::*;
	import host_cmd_pkg::*;
();

	localparam int TB_TICK_DIV = 3;
	localparam int N_ROWS = 12;
	localparam int TICK_TIMEOUT = 4 * (TB_TICK_DIV + 1);

	// How a row sets the LED request
	localparam logic [1:0] LED_FIXED = 2'd0;
	localparam logic [1:0] LED_RAND = 2'd1;
	localparam logic [1:0] LED_KEEP = 2'd2;

	typedef struct packed {
		btn_vec_t    board;
		btn_vec_t    key;
		btn_vec_t    expander;
		btn_vec_t    core;
		logic        short_press;
		logic [1:0]  led_mode;
		led_req_t    led_req;
		logic        lock;
		logic        has_frame;
		host_cmd_t   cmd;
		logic        rand_data;
		host_word_t  data;
		panel_stat_t exp_status;
	} stim_row_t;

	logic        clk_sys;
	logic        resetd;
	btn_vec_t    i_btn_board;
	btn_vec_t    i_key;
	btn_vec_t    i_btn_expander;
	btn_vec_t    i_core_btn;
	led_req_t    i_led_req;
	logic        i_pll_locked;
	logic        i_io_uio;
	logic        i_io_strobe;
	host_word_t  i_io_din;
	led_word_t   o_led;
	panel_stat_t o_status;

	stim_row_t   rows [N_ROWS];
	stim_row_t   cur_row;
	logic [31:0] lfsr_state;
	logic [15:0] rand_bits;
	led_req_t    cur_req;
	logic        cur_lock;
	host_word_t  frame_data;
	led_word_t   model_mask;
	led_word_t   model_state;
	logic [1:0]  status_seen;
	int          error_count;
	int          check_count;
	int          row_errors;

	panel_io #(
		.TICK_DIV(TB_TICK_DIV)
	) panel_io_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_btn_board   (i_btn_board),
		.i_key         (i_key),
		.i_btn_expander(i_btn_expander),
		.i_core_btn    (i_core_btn),
		.i_led_req     (i_led_req),
		.i_pll_locked  (i_pll_locked),
		.i_io_uio      (i_io_uio),
		.i_io_strobe   (i_io_strobe),
		.i_io_din      (i_io_din),
		.o_led         (o_led),
		.o_status      (o_status)
	);

	bind button_debounce panel_io_assertions panel_io_assertions_i (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_sample_tick(i_sample_tick),
		.o_level      (o_level)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	////////////////////
	// Reference LED pattern from the core requests and lock
	function automatic led_word_t default_pattern(input led_req_t req, input logic lock);
		led_word_t pat;
		logic      p;
		logic      d;
		logic      u;
		p = 1'b0;
		if (req.power_ctrl) begin
			p = ~req.power_val;
		end
		d = ~req.disk_val;
		u = ~req.user;
		pat = '0;
		pat[6] = lock;
		pat[4] = ~p;
		pat[2] = ~d;
		pat[0] = ~u;
		return pat;
	endfunction

	// Per bit, host state where the mask is set
	function automatic led_word_t mix_led(input led_word_t mask, input led_word_t state,
			input led_word_t def);
		led_word_t res;
		for (int b = 0; b < `PANEL_LED_W; b++) begin
			res[b] = mask[b] ? state[b] : def[b];
		end
		return res;
	endfunction

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	task automatic take_bits(input int n, output logic [15:0] bits);
		logic fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits = {bits[14:0], fb};
		end
	endtask

	task automatic next_drive_slot();
		@(posedge clk_sys);
		#5;
	endtask

	// Count sample ticks at falling edges, collecting any status seen
	task automatic wait_ticks(input int n);
		int cycles;
		for (int t = 0; t < n; t++) begin
			cycles = 0;
			do begin
				@(negedge clk_sys);
				cycles++;
				status_seen = status_seen | o_status;
			end while (!panel_io_i.sample_tick && cycles < TICK_TIMEOUT);
			if (!panel_io_i.sample_tick) begin
				$display("Timeout, no sample tick within %0d cycles", cycles);
				error_count++;
			end
		end
	endtask

	task automatic send_frame(input host_cmd_t cmd, input host_word_t data);
		next_drive_slot();
		i_io_uio = 1'b1;
		next_drive_slot();
		i_io_strobe = 1'b1;
		i_io_din = {8'h00, cmd};
		next_drive_slot();
		i_io_strobe = 1'b0;
		next_drive_slot();
		i_io_strobe = 1'b1;
		i_io_din = data;
		next_drive_slot();
		i_io_strobe = 1'b0;
		i_io_uio = 1'b0;
	endtask

	task automatic check_led(input int row, input led_word_t exp);
		check_count++;
		assert (o_led === exp) else begin
			$display("[FAIL] row %0d o_led got %h expected %h", row, o_led, exp);
			error_count++;
		end
	endtask

	task automatic check_status(input int row, input logic [1:0] exp);
		check_count++;
		assert (o_status === exp) else begin
			$display("[FAIL] row %0d o_status got %h expected %h", row, o_status, exp);
			error_count++;
		end
	endtask

	////////////////////
	// Row fields: board key expander core short, led mode req lock, frame cmd rand data, status
	task automatic load_rows();
		rows[0]  = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h16, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b00};
		rows[1]  = '{2'b10, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h16, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b01};
		rows[2]  = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h16, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b00};
		rows[3]  = '{2'b11, 2'b01, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h0b, 1'b0, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b10};
		rows[4]  = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h0b, 1'b0, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b00};
		rows[5]  = '{2'b11, 2'b11, 2'b11, 2'b00, 1'b0,
			LED_FIXED, 5'h1f, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b11};
		rows[6]  = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_FIXED, 5'h1f, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b00};
		// Short press on both lanes, must not reach the status bits
		rows[7]  = '{2'b00, 2'b11, 2'b00, 2'b00, 1'b1,
			LED_FIXED, 5'h16, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b00};
		rows[8]  = '{2'b11, 2'b11, 2'b00, 2'b10, 1'b0,
			LED_FIXED, 5'h16, 1'b1, 1'b0, 8'h00, 1'b0, 16'h0000, 2'b10};
		rows[9]  = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_RAND, 5'h00, 1'b0, 1'b1, 8'h25, 1'b1, 16'h0000, 2'b00};
		rows[10] = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_KEEP, 5'h00, 1'b0, 1'b1, 8'h13, 1'b1, 16'h0000, 2'b00};
		rows[11] = '{2'b11, 2'b11, 2'b00, 2'b00, 1'b0,
			LED_RAND, 5'h00, 1'b0, 1'b1, 8'h25, 1'b0, 16'h005a, 2'b00};
	endtask

	initial begin
		lfsr_state = 32'h6050;
		error_count = 0;
		check_count = 0;
		model_mask = '0;
		model_state = '0;
		status_seen = '0;
		cur_req = 5'h16;
		cur_lock = 1'b1;
		resetd = 1'b1;
		i_btn_board = 2'b11;
		i_key = 2'b11;
		i_btn_expander = 2'b00;
		i_core_btn = 2'b00;
		i_led_req = cur_req;
		i_pll_locked = cur_lock;
		i_io_uio = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din = '0;
		load_rows();

		repeat (16) @(posedge clk_sys);
		#5;
		resetd = 1'b0;
		repeat (3) @(negedge clk_sys);
		check_led(-1, default_pattern(cur_req, cur_lock));
		check_status(-1, 2'b00);
		$display("Reset check %s", (error_count == 0) ? "ok" : "mismatch");

		for (int r = 0; r < N_ROWS; r++) begin
			cur_row = rows[r];
			row_errors = error_count;
			case (cur_row.led_mode)
				LED_RAND: begin
					take_bits(5, rand_bits);
					cur_req = led_req_t'(rand_bits[4:0]);
					take_bits(1, rand_bits);
					cur_lock = rand_bits[0];
				end
				LED_FIXED: begin
					cur_req = cur_row.led_req;
					cur_lock = cur_row.lock;
				end
				default: begin
				end
			endcase

			next_drive_slot();
			i_btn_board = cur_row.board;
			i_key = cur_row.key;
			i_btn_expander = cur_row.expander;
			i_core_btn = cur_row.core;
			i_led_req = cur_req;
			i_pll_locked = cur_lock;
			status_seen = '0;

			if (cur_row.has_frame) begin
				frame_data = cur_row.data;
				if (cur_row.rand_data) begin
					take_bits(16, rand_bits);
					frame_data = rand_bits;
				end
				send_frame(cur_row.cmd, frame_data);
				if (cur_row.cmd == `PANEL_CMD_LED) begin
					model_mask = frame_data[15:8];
					model_state = frame_data[7:0];
				end
			end

			// Core button passes straight through the status register
			if (cur_row.core != '0) begin
				repeat (2) @(negedge clk_sys);
				check_count++;
				assert ((o_status & cur_row.core) == cur_row.core) else begin
					$display("[FAIL] row %0d o_status got %h expected core bits %h",
						r, o_status, cur_row.core);
					error_count++;
				end
			end

			if (cur_row.short_press) begin
				wait_ticks(2);
				next_drive_slot();
				i_btn_board = 2'b11;
				i_key = 2'b11;
				i_btn_expander = 2'b00;
				wait_ticks(10);
			end else begin
				wait_ticks(12);
			end

			check_led(r, mix_led(model_mask, model_state, default_pattern(cur_req, cur_lock)));
			check_status(r, cur_row.exp_status);
			if (cur_row.short_press) begin
				check_count++;
				assert (status_seen == 2'b00) else begin
					$display("Short press on row %0d showed up in the status bits", r);
					error_count++;
				end
			end
			$display("Row %0d %s", r, (error_count == row_errors) ? "ok" : "mismatch");
		end

		$display("Rows %0d, checks %0d, errors %0d", N_ROWS, check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* verif/panel_io_assertions.sv */
// Concurrent checks on the shared sampling tick and one lane debouncer, bound into each lane
`timescale 1ns/1ps

module panel_io_assertions (
	input logic clk_sys,
	input logic resetd,
	input logic i_sample_tick,
	input logic o_level
);

	////////////////////
	// Tick is a single-cycle pulse
	tick_single_cycle: assert property (
		@(posedge clk_sys) disable iff (resetd)
		i_sample_tick |=> !i_sample_tick
	) else $error("sample tick high on two consecutive cycles");

	// Level only moves in the cycle after a tick
	level_follows_tick: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$changed(o_level) |-> $past(i_sample_tick)
	) else $error("debounced level changed without a tick in the previous cycle");

	////////////////////
	// Synchronous reset clears the level
	reset_clears_level: assert property (
		@(posedge clk_sys)
		resetd |=> !o_level
	) else $error("debounced level not cleared one cycle after reset");

endmodule

/* source/panel_io.sv */
// Board panel top level, button sampling and debouncing, host status and LED word
`timescale 1ns/1ps
`include "panel_consts.svh"

module panel_io
	import panel_types_pkg::*;
	import host_cmd_pkg::*;
#(
	parameter int TICK_DIV = `PANEL_TICK_DIV
) (
	input  logic        clk_sys,
	input  logic        resetd,
	input  btn_vec_t    i_btn_board,
	input  btn_vec_t    i_key,
	input  btn_vec_t    i_btn_expander,
	input  btn_vec_t    i_core_btn,
	input  led_req_t    i_led_req,
	input  logic        i_pll_locked,
	input  logic        i_io_uio,
	input  logic        i_io_strobe,
	input  host_word_t  i_io_din,
	output led_word_t   o_led,
	output panel_stat_t o_status
);

	btn_vec_t pressed;
	btn_vec_t levels;
	logic     sample_tick;

	////////////////////
	button_sampler #(
		.TICK_DIV(TICK_DIV)
	) button_sampler_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_btn_board   (i_btn_board),
		.i_key         (i_key),
		.i_btn_expander(i_btn_expander),
		.o_pressed     (pressed),
		.o_sample_tick (sample_tick)
	);

	// One debouncer per lane, all on the shared tick
	for (genvar i = 0; i < `PANEL_N_BTN; i++) begin : g_lane
		button_debounce button_debounce_i (
			.clk_sys      (clk_sys),
			.resetd       (resetd),
			.i_sample_tick(sample_tick),
			.i_pressed    (pressed[i]),
			.o_level      (levels[i])
		);
	end

	////////////////////
	panel_status panel_status_i (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_levels    (levels),
		.i_core_btn  (i_core_btn),
		.i_led_req   (i_led_req),
		.i_pll_locked(i_pll_locked),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_led       (o_led),
		.o_status    (o_status)
	);

endmodule

/* source/panel_status.sv */
// Host LED command capture, LED word mixing and host status bits for the panel
`timescale 1ns/1ps
`include "panel_consts.svh"

module panel_status
	import panel_types_pkg::*;
	import host_cmd_pkg::*;
(
	input  logic        clk_sys,
	input  logic        resetd,
	input  btn_vec_t    i_levels,
	input  btn_vec_t    i_core_btn,
	input  led_req_t    i_led_req,
	input  logic        i_pll_locked,
	input  logic        i_io_uio,
	input  logic        i_io_strobe,
	input  host_word_t  i_io_din,
	output led_word_t   o_led,
	output panel_stat_t o_status
);

	cmd_phase_t phase;
	host_cmd_t  cmd;
	led_word_t  led_overtake;
	led_word_t  led_state;

	logic      led_p;
	logic      led_d;
	logic      led_u;
	led_word_t led_default;
	led_word_t led_mix;
	btn_vec_t  stat_bits;

	////////////////////
	// Command capture
	// First strobed word of a frame is the command, the rest are data
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			phase        <= CMD_IDLE;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (!i_io_uio) begin
			phase <= CMD_IDLE;
		end else if (i_io_strobe) begin
			case (phase)
				CMD_IDLE: begin
					cmd   <= i_io_din[7:0];
					phase <= CMD_DATA;
				end
				CMD_DATA: begin
					// Mask in the high byte, LED state in the low byte
					if (cmd == `PANEL_CMD_LED) begin
						led_overtake <= i_io_din[15:8];
						led_state    <= i_io_din[7:0];
					end
				end
				default: phase <= CMD_IDLE;
			endcase
		end
	end

	////////////////////
	// Default pattern from the core requests
	// Power lights only under core control
	assign led_p = i_led_req.power_ctrl ? ~i_led_req.power_val : 1'b0;
	// Disk follows its value either way
	assign led_d = ~i_led_req.disk_val;
	assign led_u = ~i_led_req.user;

	assign led_default = {1'b0, i_pll_locked, 1'b0, ~led_p, 1'b0, ~led_d, 1'b0, ~led_u};

	// Host value wins wherever its overtake bit is set
	assign led_mix = (led_overtake & led_state) | (~led_overtake & led_default);

	// Core request can press a button on its own
	assign stat_bits = i_levels | i_core_btn;

	////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_led    <= '0;
			o_status <= '0;
		end else begin
			o_led             <= led_mix;
			o_status.btn_osd  <= stat_bits[0];
			o_status.btn_user <= stat_bits[1];
		end
	end

endmodule

/* source/button_debounce.sv */
// One lane debouncer, sets on an all-ones sample history and clears on all zeros
`timescale 1ns/1ps
`include "panel_consts.svh"

module button_debounce (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sample_tick,
	input  logic i_pressed,
	output logic o_level
);

	localparam int DEPTH = `PANEL_DEB_DEPTH;

	typedef logic [DEPTH-1:0] deb_hist_t;

	deb_hist_t hist;

	////////////////////
	// History only moves on the sampling tick
	// The level looks at the history as it stood before this shift,
	// so a steady input shows up after DEPTH+1 ticks at most
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hist    <= '0;
			o_level <= 1'b0;
		end else if (i_sample_tick) begin
			hist <= {hist[DEPTH-2:0], i_pressed};
			if (&hist) begin
				o_level <= 1'b1;
			end else if (hist == '0) begin
				o_level <= 1'b0;
			end
		end
	end

endmodule

/* source/button_sampler.sv */
// Merges the raw button sources per lane and makes the slow debounce sampling tick
`timescale 1ns/1ps
`include "panel_consts.svh"

module button_sampler
	import panel_types_pkg::*;
#(
	parameter int TICK_DIV = `PANEL_TICK_DIV
) (
	input  logic     clk_sys,
	input  logic     resetd,
	input  btn_vec_t i_btn_board,
	input  btn_vec_t i_key,
	input  btn_vec_t i_btn_expander,
	output btn_vec_t o_pressed,
	output logic     o_sample_tick
);

	localparam int CNT_W = (TICK_DIV > 0) ? $clog2(TICK_DIV + 1) : 1;

	typedef logic [CNT_W-1:0] div_cnt_t;

	localparam div_cnt_t DIV_LAST = div_cnt_t'(TICK_DIV);

	div_cnt_t div_cnt;

	////////////////////
	// Board button and key are active low, expander bit is active high
	always_ff @(posedge clk_sys) begin
		o_pressed <= ~i_btn_board | ~i_key | i_btn_expander;
	end

	////////////////////
	// Free-running divider, tick on wrap
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt       <= '0;
			o_sample_tick <= 1'b0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt       <= '0;
			o_sample_tick <= 1'b1;
		end else begin
			div_cnt       <= div_cnt + 1'b1;
			o_sample_tick <= 1'b0;
		end
	end

endmodule

/* source/host_cmd_pkg.sv */
// Host word interface types and the command capture states

package host_cmd_pkg;

	// One strobed word from the host
	typedef logic [15:0] host_word_t;

	// Command code, taken from the low byte of the first word in a frame
	typedef logic [7:0] host_cmd_t;

	////////////////////
	// Capture phase within one frame
	// Idle waits for the command word, data takes the rest
	typedef enum logic {
		CMD_IDLE = 1'b0,
		CMD_DATA = 1'b1
	} cmd_phase_t;

endpackage

/* source/panel_types_pkg.sv */
// Panel signal types shared by the button path, the LED path and the testbench
`include "panel_consts.svh"

package panel_types_pkg;

	// One bit per debounced lane
	typedef logic [`PANEL_N_BTN-1:0] btn_vec_t;

	// Main-board LED word
	typedef logic [`PANEL_LED_W-1:0] led_word_t;

	////////////////////
	// LED requests from the core
	// Power and disk carry a control and a value bit
	typedef struct packed {
		logic power_ctrl;
		logic power_val;
		logic disk_ctrl;
		logic disk_val;
		logic user;
	} led_req_t;

	////////////////////
	// Status bits seen by the host, bit order follows the lanes
	typedef struct packed {
		logic btn_user;
		logic btn_osd;
	} panel_stat_t;

endpackage

/* source/panel_consts.svh */
// Shared panel constants, included by the packages, the RTL and the testbench
`ifndef PANEL_CONSTS_SVH
`define PANEL_CONSTS_SVH

// Debounced lanes, lane 0 is OSD and lane 1 is user
`define PANEL_N_BTN 2

// Samples kept per lane before the level may change
`define PANEL_DEB_DEPTH 8

// Divider terminal count, one tick every PANEL_TICK_DIV+1 cycles
`define PANEL_TICK_DIV 100000

// Host command that loads the LED overtake mask and state
`define PANEL_CMD_LED 8'h25

`define PANEL_LED_W 8

`endif
